/* Makefile */
VERILATOR ?= verilator
TOP       ?= control_unit_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(OBJ_DIR)

/* bench/control_unit_props.sv */
`timescale 1ns/1ps

module control_unit_props (
  input logic clk,
  input logic rst,
  input logic seq_push,
  input logic seq_pop,
  input logic int_ack,
  input logic fetch_pc_enable,
  input logic pop_pc1,
  input logic pop_pc2,
  input logic pop_ccr
);

  // number of failed assertions so far
  int error_count = 0;

  // no sequencer reads and writes the stack in one cycle
  push_pop_apart: assert property (@(posedge clk) disable iff (rst) !(seq_push && seq_pop))
    else
    begin
      error_count++;
      $error("sequencer stack push and pop in the same cycle");
    end

  int_ack_pulse: assert property (@(posedge clk) disable iff (rst) int_ack |=> !int_ack)
    else
    begin
      error_count++;
      $error("int_ack high for more than one cycle");
    end

  // fetch runs as soon as reset is gone
  fetch_after_reset: assert property (@(posedge clk) $fell(rst) |-> fetch_pc_enable)
    else
    begin
      error_count++;
      $error("fetch disabled in the first cycle after reset");
    end

  pops_exclusive: assert property (@(posedge clk) disable iff (rst)
                                   $onehot0({pop_pc1, pop_pc2, pop_ccr}))
    else
    begin
      error_count++;
      $error("more than one pop strobe active");
    end

endmodule

bind control_unit control_unit_props control_unit_props_i (
  .clk(clk),
  .rst(rst),
  .seq_push(seq_push),
  .seq_pop(seq_pop),
  .int_ack(int_ack),
  .fetch_pc_enable(fetch_pc_enable),
  .pop_pc1(pop_pc1),
  .pop_pc2(pop_pc2),
  .pop_ccr(pop_ccr)
);

/* bench/control_unit_tb.sv */
`timescale 1ns/1ps
`include "ctrl_params.svh"

module control_unit_tb;

  import ctrl_pkg::*;

  // reg_write mem_read mem_write mem_to_reg ldm stack branch port_read port_write
  typedef logic [8:0] flag_vec_t;

  typedef struct packed {
    logic     reg_write, mem_read, mem_write, mem_to_reg, ldm, stack, branch;
    logic     port_read, port_write, is_call, is_ret, is_rti;
    alu_src_t alu_src;
  } dec_ref_t;

  // rough length of each test in cycles
  localparam int RESET_LEN  = 8;
  localparam int DECODE_LEN = 240;
  localparam int CALL_LEN   = 14;
  localparam int POP_LEN    = 12;
  localparam int INT_LEN    = 30;
  localparam int MIXED_LEN  = 24;
  localparam int MAX_CYCLES =
    2 * (RESET_LEN + DECODE_LEN + CALL_LEN + POP_LEN + INT_LEN + MIXED_LEN) + 200;

  logic          clk = 1'b0;
  logic          rst, interrupt, load_use;
  opcode_t       opcode;
  alu_op_t       alu_op;
  alu_src_t      alu_src;
  logic          reg_write, mem_read, mem_write, mem_to_reg, ldm, stack, branch;
  logic          port_read, port_write, pop_pc1, pop_pc2, pop_ccr, int_ack;
  logic          fetch_pc_enable, freeze_cu;
  mem_data_sel_t mem_data_sel;
  pc_sel_t       pc_sel;

  // model position of each sequencer, 0 is idle
  int            call_step = 0;
  int            ret_step = 0;
  int            rti_step = 0;
  int            int_step = 0;
  int            cycle_count = 0;
  string         test_name;
  logic [15:0]   lfsr_state;

  control_unit control_unit_i (.*);

  always #50 clk = ~clk;

  task automatic stop_with_failure();
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flags(input string what, input flag_vec_t exp, input flag_vec_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_alu_op(input string what, input alu_op_t exp, input alu_op_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_alu_src(input string what, input alu_src_t exp, input alu_src_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_mem_sel(input string what, input mem_data_sel_t exp,
                               input mem_data_sel_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_pc_sel(input string what, input pc_sel_t exp, input pc_sel_t act);
    if (act !== exp)
    begin
      $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("MISMATCH %s %s expected %b actual %b", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp)
    begin
      $display("MISMATCH %s %s expected %0d actual %0d", test_name, what, exp, act);
      stop_with_failure();
    end
  endtask

  // expected decoder output from the opcode table
  function automatic dec_ref_t ref_decode(input opcode_t op);
    dec_ref_t d;
    d = '0;
    if (op >= 5'd3 && op <= 5'd5)
      d.reg_write = 1'b1;
    else if (op == `OPC_OUT)
      d.port_write = 1'b1;
    else if (op == `OPC_PUSH)
    begin
      d.mem_write = 1'b1;
      d.stack     = 1'b1;
    end
    else if (op >= 5'd8 && op <= 5'd14)
    begin
      d.reg_write = 1'b1;
      // IADD and SHIFT take the immediate
      if (op >= 5'd13)
        d.alu_src = 2'b01;
    end
    else if (op == `OPC_IN)
    begin
      d.reg_write = 1'b1;
      d.port_read = 1'b1;
    end
    else if (op == `OPC_POP)
    begin
      d.reg_write  = 1'b1;
      d.mem_read   = 1'b1;
      d.mem_to_reg = 1'b1;
      d.stack      = 1'b1;
    end
    else if (op == `OPC_LDM)
    begin
      d.reg_write = 1'b1;
      d.ldm       = 1'b1;
      d.alu_src   = 2'b10;
    end
    else if (op == `OPC_LDD)
    begin
      d.reg_write  = 1'b1;
      d.mem_read   = 1'b1;
      d.mem_to_reg = 1'b1;
    end
    else if (op == `OPC_STD)
      d.mem_write = 1'b1;
    else if (op[4:2] == 3'b101)
      d.branch = 1'b1;
    else if (op == `OPC_CALL)
      d.is_call = 1'b1;
    else if (op == `OPC_RET)
      d.is_ret = 1'b1;
    else if (op == `OPC_RTI)
      d.is_rti = 1'b1;
    return d;
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one LFSR step for every bit taken
  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[6:0], lfsr_state[0]};
    end
  endtask

  task automatic random_opcode(output opcode_t op);
    logic [7:0] v;
    do
    begin
      take_bits(5, v);
    end
    while (v[4:0] inside {`OPC_CALL, `OPC_RET, `OPC_RTI});
    op = v[4:0];
  endtask

  // sequencer cycle model, advanced on every rising edge
  task automatic step_model();
    dec_ref_t d;
    logic     others_busy;
    logic     any_busy;
    int       call_nxt, ret_nxt, rti_nxt, int_nxt;
    d = ref_decode(opcode);
    others_busy = (call_step != 0) || (ret_step != 0) || (rti_step != 0);
    any_busy    = others_busy || (int_step != 0);
    call_nxt = (call_step == 0 || call_step == 3) ? 0 : call_step + 1;
    ret_nxt  = (ret_step == 0 || ret_step == 2) ? 0 : ret_step + 1;
    rti_nxt  = (rti_step == 0 || rti_step == 3) ? 0 : rti_step + 1;
    // a pending interrupt beats any decode trigger
    if (!any_busy && !interrupt)
    begin
      if (d.is_call)
        call_nxt = 1;
      if (d.is_ret)
        ret_nxt = 1;
      if (d.is_rti)
        rti_nxt = 1;
    end
    // 1 ack, 2 wait, 3 freeze, 4..6 pushes, 7 vector
    case (int_step)
      0:
        int_nxt = (interrupt && !others_busy) ? 1 : 0;
      1:
        int_nxt = (d.ldm || load_use) ? 2 : 3;
      7:
        int_nxt = 0;
      default:
        int_nxt = int_step + 1;
    endcase
    call_step = call_nxt;
    ret_step  = ret_nxt;
    rti_step  = rti_nxt;
    int_step  = int_nxt;
  endtask

  task automatic compare_cycle();
    dec_ref_t      d;
    logic          call_busy, ret_busy, rti_busy, push, pop;
    flag_vec_t     exp_flags;
    mem_data_sel_t exp_sel;
    pc_sel_t       exp_pc;
    d = ref_decode(opcode);
    call_busy = (call_step != 0);
    ret_busy  = (ret_step != 0);
    rti_busy  = (rti_step != 0);
    push = (call_step == 1) || (call_step == 2) || (int_step >= 4 && int_step <= 6);
    pop  = ret_busy || rti_busy;
    exp_flags = {d.reg_write, d.mem_read || pop, d.mem_write || push, d.mem_to_reg, d.ldm,
                 d.stack || push || pop, d.branch, d.port_read, d.port_write};
    if (call_step == 1 || int_step == 4)
      exp_sel = 2'b01;
    else if (call_step == 2 || int_step == 5)
      exp_sel = 2'b10;
    else if (int_step == 6)
      exp_sel = 2'b11;
    else
      exp_sel = 2'b00;
    if (rst)
      exp_pc = 2'b01;
    else if (call_step == 3)
      exp_pc = 2'b11;
    else if (int_step == 7)
      exp_pc = 2'b10;
    else
      exp_pc = 2'b00;
    check_flags("flags", exp_flags, {reg_write, mem_read, mem_write, mem_to_reg, ldm, stack,
                                     branch, port_read, port_write});
    check_alu_op("alu_op", opcode, alu_op);
    check_alu_src("alu_src", d.alu_src, alu_src);
    check_mem_sel("mem_data_sel", exp_sel, mem_data_sel);
    check_pc_sel("pc_sel", exp_pc, pc_sel);
    check_bit("pop_pc1", ret_step == 2 || rti_step == 3, pop_pc1);
    check_bit("pop_pc2", ret_step == 1 || rti_step == 2, pop_pc2);
    check_bit("pop_ccr", rti_step == 1, pop_ccr);
    check_bit("int_ack", int_step == 1, int_ack);
    check_bit("fetch_pc_enable", !(call_busy || ret_busy || rti_busy || int_step >= 3),
              fetch_pc_enable);
    check_bit("freeze_cu", load_use || call_busy || ret_busy || rti_busy || int_step >= 4,
              freeze_cu);
  endtask

  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      call_step = 0;
      ret_step  = 0;
      rti_step  = 0;
      int_step  = 0;
    end
    else
      step_model();
  end

  always @(negedge clk)
    compare_cycle();

  // bound assertions on the DUT
  always @(negedge clk)
  begin
    if (control_unit_i.control_unit_props_i.error_count != 0)
    begin
      $display("a bound assertion on the DUT failed");
      stop_with_failure();
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES)
    begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      stop_with_failure();
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // counts the cycles with fetch stopped
  task automatic wait_release(output int busy_cycles);
    busy_cycles = 0;
    @(negedge clk);
    while (!fetch_pc_enable)
    begin
      busy_cycles++;
      @(negedge clk);
    end
    next_cycle();
  endtask

  // runs until the vector cycle, counting from int_ack and releasing the request
  task automatic run_int_sequence(output int cycles, output logic call_first);
    logic started;
    logic done;
    started    = 1'b0;
    done       = 1'b0;
    cycles     = 0;
    call_first = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      if (!started && pc_sel == 2'b11)
        call_first = 1'b1;
      if (int_ack)
        started = 1'b1;
      if (started)
        cycles++;
      done = started && (pc_sel == 2'b10);
      next_cycle();
      if (started)
      begin
        interrupt = 1'b0;
        load_use  = 1'b0;
        opcode    = `OPC_NOP;
      end
    end
  endtask

  initial
  begin
    int         n;
    logic       call_first;
    logic [7:0] v;
    rst        = 1'b1;
    interrupt  = 1'b0;
    load_use   = 1'b0;
    opcode     = `OPC_NOP;
    lfsr_state = 16'd10533;
    test_name  = "reset";
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    next_cycle();

    test_name = "decode sweep";
    for (int i = 0; i < 32; i++)
    begin
      opcode = opcode_t'(i);
      take_bits(1, v);
      load_use = v[0];
      next_cycle();
    end
    test_name = "decode random";
    repeat (200)
    begin
      random_opcode(opcode);
      take_bits(1, v);
      load_use = v[0];
      next_cycle();
    end
    opcode   = `OPC_NOP;
    load_use = 1'b0;
    next_cycle();

    test_name = "call";
    opcode = `OPC_CALL;
    next_cycle();
    opcode = `OPC_NOP;
    wait_release(n);
    check_count("busy cycles", 3, n);
    // CALL stays in decode into the first busy cycle
    test_name = "call held";
    opcode = `OPC_CALL;
    next_cycle();
    next_cycle();
    opcode = `OPC_NOP;
    wait_release(n);
    check_count("busy cycles left", 2, n);

    test_name = "ret";
    opcode = `OPC_RET;
    next_cycle();
    opcode = `OPC_NOP;
    wait_release(n);
    check_count("busy cycles", 2, n);
    test_name = "rti";
    opcode = `OPC_RTI;
    next_cycle();
    opcode = `OPC_NOP;
    wait_release(n);
    check_count("busy cycles", 3, n);

    test_name = "interrupt";
    interrupt = 1'b1;
    next_cycle();
    run_int_sequence(n, call_first);
    check_count("cycles from int_ack", 6, n);
    test_name = "interrupt ldm";
    interrupt = 1'b1;
    next_cycle();
    opcode = `OPC_LDM;
    run_int_sequence(n, call_first);
    check_count("cycles from int_ack", 7, n);
    test_name = "interrupt load_use";
    interrupt = 1'b1;
    next_cycle();
    load_use = 1'b1;
    run_int_sequence(n, call_first);
    check_count("cycles from int_ack", 7, n);

    test_name = "interrupt during call";
    opcode = `OPC_CALL;
    next_cycle();
    opcode    = `OPC_NOP;
    interrupt = 1'b1;
    run_int_sequence(n, call_first);
    check_bit("call target before int_ack", 1'b1, call_first);
    check_count("cycles from int_ack", 6, n);
    test_name = "rti against interrupt";
    opcode    = `OPC_RTI;
    interrupt = 1'b1;
    run_int_sequence(n, call_first);
    check_count("cycles from int_ack", 6, n);
    next_cycle();

    if (control_unit_i.control_unit_props_i.error_count != 0)
    begin
      $display("a bound assertion on the DUT failed");
      stop_with_failure();
    end
    else
    begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* build.f */
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/call_seq.sv
rtl/ret_seq.sv
rtl/rti_seq.sv
rtl/int_seq.sv
rtl/control_unit.sv
bench/control_unit_props.sv
bench/control_unit_tb.sv

/* rtl/call_seq.sv */
`timescale 1ns/1ps

module call_seq (
  input  logic              clk,
  input  logic              rst,
  input  logic              call,
  input  logic              hold,
  output logic              busy,
  output logic              push_pc1,
  output logic              push_pc2,
  output logic              freeze_pc,
  output logic              freeze_cu,
  output ctrl_pkg::pc_sel_t pc_sel
);

  import ctrl_pkg::*;

  call_state_t state;
  call_state_t state_nxt;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= CALL_IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      CALL_IDLE:
        if (call && !hold)
          state_nxt = CALL_PUSH_PC1;
      CALL_PUSH_PC1:
        state_nxt = CALL_PUSH_PC2;
      CALL_PUSH_PC2:
        state_nxt = CALL_LOAD_PC;
      default:
        state_nxt = CALL_IDLE;
    endcase
  end

  // return address goes out as two words, then the target is loaded
  assign busy      = (state != CALL_IDLE);
  assign push_pc1  = (state == CALL_PUSH_PC1);
  assign push_pc2  = (state == CALL_PUSH_PC2);
  assign freeze_pc = busy;
  assign freeze_cu = busy;
  assign pc_sel    = (state == CALL_LOAD_PC) ? 2'b11 : 2'b00;

endmodule

/* rtl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    interrupt,
  input  logic                    load_use,
  input  ctrl_pkg::opcode_t       opcode,
  output ctrl_pkg::alu_op_t       alu_op,
  output ctrl_pkg::alu_src_t      alu_src,
  output logic                    reg_write,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic                    mem_to_reg,
  output logic                    ldm,
  output logic                    stack,
  output logic                    branch,
  output logic                    port_read,
  output logic                    port_write,
  output ctrl_pkg::mem_data_sel_t mem_data_sel,
  output ctrl_pkg::pc_sel_t       pc_sel,
  output logic                    pop_pc1,
  output logic                    pop_pc2,
  output logic                    pop_ccr,
  output logic                    int_ack,
  output logic                    fetch_pc_enable,
  output logic                    freeze_cu
);

  import ctrl_pkg::*;

  logic    dec_mem_read, dec_mem_write, dec_stack;
  logic    is_call, is_ret, is_rti;
  logic    call_busy, call_push_pc1, call_push_pc2, call_freeze_pc, call_freeze_cu;
  logic    ret_busy, ret_pop_pc1, ret_pop_pc2, ret_freeze_pc, ret_freeze_cu;
  logic    rti_busy, rti_pop_pc1, rti_pop_pc2, rti_pop_ccr, rti_freeze_pc, rti_freeze_cu;
  logic    int_busy, int_push_pc1, int_push_pc2, int_push_ccr, int_freeze_pc, int_freeze_cu;
  logic    seq_busy, seq_hold, int_hold;
  logic    seq_push, seq_pop;
  pc_sel_t call_pc_sel, int_pc_sel;

  instr_decoder decoder_i (
    .opcode(opcode), .alu_op(alu_op), .alu_src(alu_src), .reg_write(reg_write),
    .mem_read(dec_mem_read), .mem_write(dec_mem_write), .mem_to_reg(mem_to_reg),
    .ldm(ldm), .stack(dec_stack), .branch(branch), .port_read(port_read),
    .port_write(port_write), .is_call(is_call), .is_ret(is_ret), .is_rti(is_rti)
  );

  // an interrupt request outranks any sequencer trigger in decode
  assign seq_busy = call_busy || ret_busy || rti_busy || int_busy;
  assign seq_hold = seq_busy || interrupt;
  assign int_hold = call_busy || ret_busy || rti_busy;

  call_seq call_seq_i (
    .clk(clk), .rst(rst), .call(is_call), .hold(seq_hold), .busy(call_busy),
    .push_pc1(call_push_pc1), .push_pc2(call_push_pc2), .freeze_pc(call_freeze_pc),
    .freeze_cu(call_freeze_cu), .pc_sel(call_pc_sel)
  );

  ret_seq ret_seq_i (
    .clk(clk), .rst(rst), .ret(is_ret), .hold(seq_hold), .busy(ret_busy),
    .pop_pc1(ret_pop_pc1), .pop_pc2(ret_pop_pc2), .freeze_pc(ret_freeze_pc),
    .freeze_cu(ret_freeze_cu)
  );

  rti_seq rti_seq_i (
    .clk(clk), .rst(rst), .rti(is_rti), .hold(seq_hold), .busy(rti_busy),
    .pop_ccr(rti_pop_ccr), .pop_pc1(rti_pop_pc1), .pop_pc2(rti_pop_pc2),
    .freeze_pc(rti_freeze_pc), .freeze_cu(rti_freeze_cu)
  );

  int_seq int_seq_i (
    .clk(clk), .rst(rst), .interrupt(interrupt), .hold(int_hold), .ldm(ldm),
    .load_use(load_use), .busy(int_busy), .int_ack(int_ack), .push_pc1(int_push_pc1),
    .push_pc2(int_push_pc2), .push_ccr(int_push_ccr), .freeze_pc(int_freeze_pc),
    .freeze_cu(int_freeze_cu), .pc_sel(int_pc_sel)
  );

  // stack traffic requested by the sequencers
  assign seq_push = call_push_pc1 || call_push_pc2 || int_push_pc1 || int_push_pc2
                    || int_push_ccr;
  assign seq_pop  = ret_pop_pc1 || ret_pop_pc2 || rti_pop_ccr || rti_pop_pc1 || rti_pop_pc2;

  assign mem_write = dec_mem_write || seq_push;
  assign mem_read  = dec_mem_read || seq_pop;
  assign stack     = dec_stack || seq_push || seq_pop;

  assign mem_data_sel = (call_push_pc1 || int_push_pc1) ? 2'b01 :
                        (call_push_pc2 || int_push_pc2) ? 2'b10 :
                        int_push_ccr                    ? 2'b11 : 2'b00;

  assign pop_pc1 = ret_pop_pc1 || rti_pop_pc1;
  assign pop_pc2 = ret_pop_pc2 || rti_pop_pc2;
  assign pop_ccr = rti_pop_ccr;

  // sequencers are idle in reset, so this reads as the reset vector
  assign pc_sel = call_pc_sel | int_pc_sel | {1'b0, rst};

  assign freeze_cu = load_use || call_freeze_cu || ret_freeze_cu || rti_freeze_cu
                     || int_freeze_cu;
  assign fetch_pc_enable = !(call_freeze_pc || ret_freeze_pc || rti_freeze_pc
                             || int_freeze_pc);

endmodule

/* rtl/ctrl_params.svh */
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// instruction opcode width
`define OPC_W 5

// one-operand and flag instructions
`define OPC_NOP   5'b00000
`define OPC_SETC  5'b00001
`define OPC_CLRC  5'b00010
`define OPC_NOT   5'b00011
`define OPC_INC   5'b00100
`define OPC_DEC   5'b00101
`define OPC_OUT   5'b00110
`define OPC_PUSH  5'b00111

// two-operand and immediate instructions
`define OPC_IADD  5'b01101
`define OPC_SHIFT 5'b01110
`define OPC_IN    5'b01111

// memory instructions
`define OPC_POP   5'b10000
`define OPC_LDM   5'b10001
`define OPC_LDD   5'b10010
`define OPC_STD   5'b10011

// control transfer handled by the sequencers
`define OPC_CALL  5'b11000
`define OPC_RET   5'b11001
`define OPC_RTI   5'b11010

`endif

/* rtl/ctrl_pkg.sv */
`include "ctrl_params.svh"

package ctrl_pkg;

  // instruction opcode as seen in decode
  typedef logic [`OPC_W-1:0] opcode_t;

  // the ALU operation is the opcode itself
  typedef logic [`OPC_W-1:0] alu_op_t;

  // second ALU operand
  // 00 register, 01 immediate, 10 LDM immediate
  typedef logic [1:0] alu_src_t;

  // next PC source
  // 00 PC+1, 01 reset vector, 10 interrupt vector, 11 call target
  typedef logic [1:0] pc_sel_t;

  // word written to the stack
  // 00 register, 01 PC word 1, 10 PC word 2, 11 flags
  typedef logic [1:0] mem_data_sel_t;

  typedef enum logic [1:0] {
    CALL_IDLE,
    CALL_PUSH_PC1,
    CALL_PUSH_PC2,
    CALL_LOAD_PC
  } call_state_t;

  typedef enum logic [1:0] {
    RET_IDLE,
    RET_POP_PC2,
    RET_POP_PC1
  } ret_state_t;

  typedef enum logic [1:0] {
    RTI_IDLE,
    RTI_POP_CCR,
    RTI_POP_PC2,
    RTI_POP_PC1
  } rti_state_t;

  typedef enum logic [2:0] {
    INT_IDLE,
    INT_ACK,
    INT_WAIT,
    INT_FREEZE,
    INT_PUSH_PC1,
    INT_PUSH_PC2,
    INT_PUSH_CCR,
    INT_VECTOR
  } int_state_t;

endpackage

/* rtl/instr_decoder.sv */
`timescale 1ns/1ps
`include "ctrl_params.svh"

module instr_decoder (
  input  ctrl_pkg::opcode_t  opcode,
  output ctrl_pkg::alu_op_t  alu_op,
  output ctrl_pkg::alu_src_t alu_src,
  output logic               reg_write,
  output logic               mem_read,
  output logic               mem_write,
  output logic               mem_to_reg,
  output logic               ldm,
  output logic               stack,
  output logic               branch,
  output logic               port_read,
  output logic               port_write,
  output logic               is_call,
  output logic               is_ret,
  output logic               is_rti
);

  // opcode goes straight through as the ALU operation
  assign alu_op = opcode;

  always_comb
  begin
    alu_src    = 2'b00;
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    mem_to_reg = 1'b0;
    ldm        = 1'b0;
    stack      = 1'b0;
    branch     = 1'b0;
    port_read  = 1'b0;
    port_write = 1'b0;
    is_call    = 1'b0;
    is_ret     = 1'b0;
    is_rti     = 1'b0;
    case (opcode) inside
      `OPC_NOT, `OPC_INC, `OPC_DEC:
        reg_write = 1'b1;
      `OPC_OUT:
        port_write = 1'b1;
      `OPC_PUSH:
      begin
        mem_write = 1'b1;
        stack     = 1'b1;
      end
      // register-register group, no named opcodes of its own here
      [5'b01000:5'b01100]:
        reg_write = 1'b1;
      `OPC_IADD, `OPC_SHIFT:
      begin
        reg_write = 1'b1;
        alu_src   = 2'b01;
      end
      `OPC_IN:
      begin
        reg_write = 1'b1;
        port_read = 1'b1;
      end
      `OPC_POP:
      begin
        reg_write  = 1'b1;
        mem_read   = 1'b1;
        mem_to_reg = 1'b1;
        stack      = 1'b1;
      end
      `OPC_LDM:
      begin
        reg_write = 1'b1;
        ldm       = 1'b1;
        alu_src   = 2'b10;
      end
      `OPC_LDD:
      begin
        reg_write  = 1'b1;
        mem_read   = 1'b1;
        mem_to_reg = 1'b1;
      end
      `OPC_STD:
        mem_write = 1'b1;
      // all conditional and unconditional jumps
      5'b101??:
        branch = 1'b1;
      `OPC_CALL:
        is_call = 1'b1;
      `OPC_RET:
        is_ret = 1'b1;
      `OPC_RTI:
        is_rti = 1'b1;
      // NOP, SETC, CLRC and the reserved codes drive nothing
      default:
        ;
    endcase
  end

endmodule

/* rtl/int_seq.sv */
`timescale 1ns/1ps

module int_seq (
  input  logic              clk,
  input  logic              rst,
  input  logic              interrupt,
  input  logic              hold,
  input  logic              ldm,
  input  logic              load_use,
  output logic              busy,
  output logic              int_ack,
  output logic              push_pc1,
  output logic              push_pc2,
  output logic              push_ccr,
  output logic              freeze_pc,
  output logic              freeze_cu,
  output ctrl_pkg::pc_sel_t pc_sel
);

  import ctrl_pkg::*;

  int_state_t state;
  int_state_t state_nxt;
  logic       pushing;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= INT_IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      INT_IDLE:
        if (interrupt && !hold)
          state_nxt = INT_ACK;
      // an LDM or load-use stall in flight needs one more cycle to settle
      INT_ACK:
        state_nxt = (ldm || load_use) ? INT_WAIT : INT_FREEZE;
      INT_WAIT:
        state_nxt = INT_FREEZE;
      INT_FREEZE:
        state_nxt = INT_PUSH_PC1;
      INT_PUSH_PC1:
        state_nxt = INT_PUSH_PC2;
      INT_PUSH_PC2:
        state_nxt = INT_PUSH_CCR;
      INT_PUSH_CCR:
        state_nxt = INT_VECTOR;
      default:
        state_nxt = INT_IDLE;
    endcase
  end

  assign busy     = (state != INT_IDLE);
  assign int_ack  = (state == INT_ACK);
  assign push_pc1 = (state == INT_PUSH_PC1);
  assign push_pc2 = (state == INT_PUSH_PC2);
  assign push_ccr = (state == INT_PUSH_CCR);
  assign pushing  = push_pc1 || push_pc2 || push_ccr;

  // fetch stops first so the pipeline drains, decode stops once pushes start
  assign freeze_pc = (state == INT_FREEZE) || pushing || (state == INT_VECTOR);
  assign freeze_cu = pushing || (state == INT_VECTOR);
  assign pc_sel    = (state == INT_VECTOR) ? 2'b10 : 2'b00;

endmodule

/* rtl/ret_seq.sv */
`timescale 1ns/1ps

module ret_seq (
  input  logic clk,
  input  logic rst,
  input  logic ret,
  input  logic hold,
  output logic busy,
  output logic pop_pc1,
  output logic pop_pc2,
  output logic freeze_pc,
  output logic freeze_cu
);

  import ctrl_pkg::*;

  ret_state_t state;
  ret_state_t state_nxt;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= RET_IDLE;
    else
      state <= state_nxt;
  end

  // high word comes off the stack first
  always_comb
  begin
    state_nxt = state;
    case (state)
      RET_IDLE:
        if (ret && !hold)
          state_nxt = RET_POP_PC2;
      RET_POP_PC2:
        state_nxt = RET_POP_PC1;
      default:
        state_nxt = RET_IDLE;
    endcase
  end

  assign busy      = (state != RET_IDLE);
  assign pop_pc2   = (state == RET_POP_PC2);
  assign pop_pc1   = (state == RET_POP_PC1);
  assign freeze_pc = busy;
  assign freeze_cu = busy;

endmodule

/* rtl/rti_seq.sv */
`timescale 1ns/1ps

module rti_seq (
  input  logic clk,
  input  logic rst,
  input  logic rti,
  input  logic hold,
  output logic busy,
  output logic pop_ccr,
  output logic pop_pc1,
  output logic pop_pc2,
  output logic freeze_pc,
  output logic freeze_cu
);

  import ctrl_pkg::*;

  rti_state_t state;
  rti_state_t state_nxt;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= RTI_IDLE;
    else
      state <= state_nxt;
  end

  // unwinds the interrupt frame in reverse push order
  always_comb
  begin
    state_nxt = state;
    case (state)
      RTI_IDLE:
        if (rti && !hold)
          state_nxt = RTI_POP_CCR;
      RTI_POP_CCR:
        state_nxt = RTI_POP_PC2;
      RTI_POP_PC2:
        state_nxt = RTI_POP_PC1;
      default:
        state_nxt = RTI_IDLE;
    endcase
  end

  assign busy      = (state != RTI_IDLE);
  assign pop_ccr   = (state == RTI_POP_CCR);
  assign pop_pc2   = (state == RTI_POP_PC2);
  assign pop_pc1   = (state == RTI_POP_PC1);
  // every busy cycle is a stack read
  assign freeze_pc = busy;
  assign freeze_cu = busy;

endmodule
